//--- rtl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and address width
`define CPU_XLEN 64

// general registers, and the same number of flags
`define CPU_NREGS 8

// word address of the first instruction
`define CPU_RESET_PC 64'h0

`endif

//--- rtl/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

    // codes below 8 write a register, 8 to 11 write a flag
    typedef enum logic [5:0] {
        OP_ADD  = 6'd0,
        OP_SUB  = 6'd1,
        OP_AND  = 6'd2,
        OP_OR   = 6'd3,
        OP_XOR  = 6'd4,
        OP_LDI  = 6'd5,
        OP_CEQ  = 6'd8,
        OP_CLT  = 6'd9,
        OP_FAND = 6'd10,
        OP_FOR  = 6'd11,
        OP_BRF  = 6'd16,
        OP_JMP  = 6'd17,
        OP_ST   = 6'd18,
        OP_STF  = 6'd19,
        OP_HALT = 6'd20,
        OP_NOP  = 6'd63
    } opcode_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        DROP,
        WAIT_RETIRE
    } fetch_state_t;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_REG,
        KIND_FLAG,
        KIND_STORE
    } wb_kind_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } fetch_pkt_t;

    typedef struct packed {
        opcode_t     op;
        reg_idx_t    dest;
        logic        hl;
        logic [31:0] imm;
        word_t       a;
        word_t       b;
        logic        fa;
        logic        fb;
        word_t       pc;
    } decode_pkt_t;

    typedef struct packed {
        wb_kind_t kind;
        reg_idx_t dest;
        word_t    result;
        logic     flag_result;
        word_t    store_addr;
        word_t    next_pc;
        logic     halt;
    } exec_pkt_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } retire_pkt_t;

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_stage
    import cpu_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         retire,
    input  word_t        retire_pc,
    input  logic         halted,
    output logic         imem_req,
    output word_t        imem_addr,
    input  logic         imem_ack,
    input  word_t        imem_data,
    output logic         fetch_valid,
    output fetch_pkt_t   fetch_pkt
);

    fetch_state_t state;
    word_t        pc;

    assign imem_addr = pc;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state       <= IDLE;
            imem_req    <= 1'b0;
            fetch_valid <= 1'b0;
            pc          <= `CPU_RESET_PC;
        end
        else
        begin
            fetch_valid <= 1'b0;
            case (state)
                IDLE:
                    if (!halted)
                    begin
                        imem_req <= 1'b1;
                        state    <= REQ;
                    end
                REQ:
                    if (imem_ack)
                    begin
                        imem_req <= 1'b0;
                        state    <= DROP;
                    end
                // packet goes out once memory has released ack
                DROP:
                    if (!imem_ack)
                    begin
                        fetch_valid <= 1'b1;
                        state       <= WAIT_RETIRE;
                    end
                WAIT_RETIRE:
                    if (retire)
                    begin
                        pc <= retire_pc;
                        if (halted)
                        begin
                            state <= IDLE;
                        end
                        else
                        begin
                            imem_req <= 1'b1;
                            state    <= REQ;
                        end
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // instruction word is captured while ack is high
    always_ff @(posedge clock)
    begin
        if (state == REQ && imem_ack)
        begin
            fetch_pkt.instr <= imem_data;
            fetch_pkt.pc    <= pc;
        end
    end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file
    import cpu_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  reg_idx_t              ra_idx,
    input  reg_idx_t              rb_idx,
    output word_t                 ra_data,
    output word_t                 rb_data,
    output logic                  fa,
    output logic                  fb,
    output logic [`CPU_NREGS-1:0] flags,
    input  logic                  we,
    input  logic                  fwe,
    input  reg_idx_t              w_idx,
    input  word_t                 w_data,
    input  logic                  f_data
);

    word_t                 regs [`CPU_NREGS];
    logic [`CPU_NREGS-1:0] flag_q;

    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];
    assign fa      = flag_q[ra_idx];
    assign fb      = flag_q[rb_idx];
    assign flags   = flag_q;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
            begin
                regs[i] <= '0;
            end
            flag_q <= '0;
        end
        else
        begin
            if (we)
            begin
                regs[w_idx] <= w_data;
            end
            if (fwe)
            begin
                flag_q[w_idx] <= f_data;
            end
        end
    end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import cpu_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        fetch_valid,
    input  fetch_pkt_t  fetch_pkt,
    output reg_idx_t    ra_idx,
    output reg_idx_t    rb_idx,
    input  word_t       ra_data,
    input  word_t       rb_data,
    input  logic        fa,
    input  logic        fb,
    output logic        decode_valid,
    output decode_pkt_t decode_pkt
);

    opcode_t  op;
    reg_idx_t dest;

    always_comb
    begin
        case (fetch_pkt.instr[5:0])
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI,
            OP_CEQ, OP_CLT, OP_FAND, OP_FOR,
            OP_BRF, OP_JMP, OP_ST, OP_STF, OP_HALT:
                op = opcode_t'(fetch_pkt.instr[5:0]);
            default:
                op = OP_NOP;
        endcase
    end

    assign dest   = fetch_pkt.instr[14:12];
    assign ra_idx = fetch_pkt.instr[8:6];
    // LDI needs the old destination value to keep the other half
    assign rb_idx = (op == OP_LDI) ? dest : fetch_pkt.instr[11:9];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            decode_valid <= 1'b0;
        end
        else
        begin
            decode_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clock)
    begin
        if (fetch_valid)
        begin
            decode_pkt.op   <= op;
            decode_pkt.dest <= dest;
            decode_pkt.hl   <= fetch_pkt.instr[15];
            decode_pkt.imm  <= fetch_pkt.instr[63:32];
            decode_pkt.a    <= ra_data;
            decode_pkt.b    <= rb_data;
            decode_pkt.fa   <= fa;
            decode_pkt.fb   <= fb;
            decode_pkt.pc   <= fetch_pkt.pc;
        end
    end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  decode_valid,
    input  decode_pkt_t           decode_pkt,
    input  logic [`CPU_NREGS-1:0] flags,
    output logic                  exec_valid,
    output exec_pkt_t             exec_pkt
);

    exec_pkt_t nxt;
    logic      take_branch;

    assign take_branch = (decode_pkt.op == OP_JMP) || (decode_pkt.op == OP_BRF && decode_pkt.fa);

    always_comb
    begin
        nxt            = '0;
        nxt.dest       = decode_pkt.dest;
        nxt.store_addr = decode_pkt.a;
        nxt.halt       = (decode_pkt.op == OP_HALT);

        case (decode_pkt.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI:
                nxt.kind = KIND_REG;
            OP_CEQ, OP_CLT, OP_FAND, OP_FOR:
                nxt.kind = KIND_FLAG;
            OP_ST, OP_STF:
                nxt.kind = KIND_STORE;
            default:
                nxt.kind = KIND_NONE;
        endcase

        case (decode_pkt.op)
            OP_ADD: nxt.result = decode_pkt.a + decode_pkt.b;
            OP_SUB: nxt.result = decode_pkt.a - decode_pkt.b;
            OP_AND: nxt.result = decode_pkt.a & decode_pkt.b;
            OP_OR:  nxt.result = decode_pkt.a | decode_pkt.b;
            OP_XOR: nxt.result = decode_pkt.a ^ decode_pkt.b;
            // b carries the old destination here
            OP_LDI:
                if (decode_pkt.hl)
                begin
                    nxt.result = {decode_pkt.imm, decode_pkt.b[31:0]};
                end
                else
                begin
                    nxt.result = {decode_pkt.b[63:32], decode_pkt.imm};
                end
            OP_ST:  nxt.result = decode_pkt.b;
            OP_STF: nxt.result = {{(`CPU_XLEN-`CPU_NREGS){1'b0}}, flags};
            default: nxt.result = '0;
        endcase

        case (decode_pkt.op)
            OP_CEQ:  nxt.flag_result = (decode_pkt.a == decode_pkt.b);
            OP_CLT:  nxt.flag_result = (decode_pkt.a < decode_pkt.b);
            OP_FAND: nxt.flag_result = decode_pkt.fa & decode_pkt.fb;
            OP_FOR:  nxt.flag_result = decode_pkt.fa | decode_pkt.fb;
            default: nxt.flag_result = 1'b0;
        endcase

        // pc counts words, branch targets are absolute
        if (take_branch)
        begin
            nxt.next_pc = word_t'(decode_pkt.imm);
        end
        else
        begin
            nxt.next_pc = decode_pkt.pc + 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            exec_valid <= 1'b0;
        end
        else
        begin
            exec_valid <= decode_valid;
        end
    end

    always_ff @(posedge clock)
    begin
        if (decode_valid)
        begin
            exec_pkt <= nxt;
        end
    end

endmodule

//--- rtl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage
    import cpu_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      exec_valid,
    input  exec_pkt_t exec_pkt,
    output logic      we,
    output logic      fwe,
    output reg_idx_t  w_idx,
    output word_t     w_data,
    output logic      f_data,
    output logic      dmem_req,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    input  logic      dmem_ack,
    output logic      retire,
    output word_t     retire_pc,
    output logic      halted
);

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_REQ,
        WB_DROP
    } wb_state_t;

    wb_state_t   state;
    retire_pkt_t retire_q;
    logic        is_store;

    assign is_store = exec_valid && exec_pkt.kind == KIND_STORE;

    assign we        = exec_valid && exec_pkt.kind == KIND_REG;
    assign fwe       = exec_valid && exec_pkt.kind == KIND_FLAG;
    assign w_idx     = exec_pkt.dest;
    assign w_data    = exec_pkt.result;
    assign f_data    = exec_pkt.flag_result;
    assign retire    = retire_q.valid;
    assign retire_pc = retire_q.pc;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state    <= WB_IDLE;
            dmem_req <= 1'b0;
            retire_q <= '0;
            halted   <= 1'b0;
        end
        else
        begin
            retire_q.valid <= 1'b0;
            case (state)
                WB_IDLE:
                    if (is_store)
                    begin
                        dmem_req <= 1'b1;
                        state    <= WB_REQ;
                    end
                    else if (exec_valid)
                    begin
                        retire_q <= '{valid: 1'b1, pc: exec_pkt.next_pc};
                        if (exec_pkt.halt)
                        begin
                            halted <= 1'b1;
                        end
                    end
                WB_REQ:
                    if (dmem_ack)
                    begin
                        dmem_req <= 1'b0;
                        state    <= WB_DROP;
                    end
                // execute holds its packet until the next instruction arrives
                WB_DROP:
                    if (!dmem_ack)
                    begin
                        retire_q <= '{valid: 1'b1, pc: exec_pkt.next_pc};
                        state    <= WB_IDLE;
                    end
                default:
                    state <= WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (is_store && state == WB_IDLE)
        begin
            dmem_addr  <= exec_pkt.store_addr;
            dmem_wdata <= exec_pkt.result;
        end
    end

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    output logic  imem_req,
    output word_t imem_addr,
    input  logic  imem_ack,
    input  word_t imem_data,
    output logic  dmem_req,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    input  logic  dmem_ack,
    output logic  halted,
    output logic  retire
);

    fetch_pkt_t            fetch_pkt;
    decode_pkt_t           decode_pkt;
    exec_pkt_t             exec_pkt;
    logic                  fetch_valid;
    logic                  decode_valid;
    logic                  exec_valid;
    wire retire_pkt_t      ret;

    reg_idx_t              ra_idx;
    reg_idx_t              rb_idx;
    word_t                 ra_data;
    word_t                 rb_data;
    logic                  fa;
    logic                  fb;
    logic [`CPU_NREGS-1:0] flags;
    logic                  we;
    logic                  fwe;
    reg_idx_t              w_idx;
    word_t                 w_data;
    logic                  f_data;

    assign retire = ret.valid;

    fetch_stage u_fetch (
        .clock       (clock),
        .reset       (reset),
        .retire      (ret.valid),
        .retire_pc   (ret.pc),
        .halted      (halted),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_ack    (imem_ack),
        .imem_data   (imem_data),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt)
    );

    reg_file u_regs (
        .clock   (clock),
        .reset   (reset),
        .ra_idx  (ra_idx),
        .rb_idx  (rb_idx),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .fa      (fa),
        .fb      (fb),
        .flags   (flags),
        .we      (we),
        .fwe     (fwe),
        .w_idx   (w_idx),
        .w_data  (w_data),
        .f_data  (f_data)
    );

    decode_stage u_decode (
        .clock        (clock),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_pkt    (fetch_pkt),
        .ra_idx       (ra_idx),
        .rb_idx       (rb_idx),
        .ra_data      (ra_data),
        .rb_data      (rb_data),
        .fa           (fa),
        .fb           (fb),
        .decode_valid (decode_valid),
        .decode_pkt   (decode_pkt)
    );

    execute_stage u_execute (
        .clock        (clock),
        .reset        (reset),
        .decode_valid (decode_valid),
        .decode_pkt   (decode_pkt),
        .flags        (flags),
        .exec_valid   (exec_valid),
        .exec_pkt     (exec_pkt)
    );

    writeback_stage u_writeback (
        .clock      (clock),
        .reset      (reset),
        .exec_valid (exec_valid),
        .exec_pkt   (exec_pkt),
        .we         (we),
        .fwe        (fwe),
        .w_idx      (w_idx),
        .w_data     (w_data),
        .f_data     (f_data),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ack   (dmem_ack),
        .retire     (ret.valid),
        .retire_pc  (ret.pc),
        .halted     (halted)
    );

endmodule

//--- test/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

typedef struct packed {
    word_t addr;
    word_t data;
} store_rec_t;

logic [15:0] lfsr_state = 16'd14048;

word_t      m_regs [`CPU_NREGS];
logic [7:0] m_flags;
word_t      exp_pcs [$];
store_rec_t exp_stores [$];

// galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// one lfsr step per bit taken
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
        v = {v[62:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
endfunction

// runs prog one instruction at a time and records fetch addresses and stores
function automatic void run_model();
    word_t       pc;
    word_t       next_pc;
    word_t       w;
    word_t       a;
    word_t       b;
    logic [2:0]  ra;
    logic [2:0]  rb;
    logic [2:0]  d;
    logic [31:0] imm;
    logic        done;
    store_rec_t  rec;
    int          n;
    pc = `CPU_RESET_PC;
    m_flags = '0;
    for (n = 0; n < `CPU_NREGS; n++)
    begin
        m_regs[n] = '0;
    end
    exp_pcs.delete();
    exp_stores.delete();
    done = 1'b0;
    for (n = 0; n < 64 && !done; n++)
    begin
        exp_pcs.push_back(pc);
        w       = prog[pc[5:0]];
        ra      = w[8:6];
        rb      = w[11:9];
        d       = w[14:12];
        imm     = w[63:32];
        a       = m_regs[ra];
        b       = m_regs[rb];
        next_pc = pc + 64'd1;
        case (w[5:0])
            OP_ADD:  m_regs[d] = a + b;
            OP_SUB:  m_regs[d] = a - b;
            OP_AND:  m_regs[d] = a & b;
            OP_OR:   m_regs[d] = a | b;
            OP_XOR:  m_regs[d] = a ^ b;
            OP_LDI:  m_regs[d] = w[15] ? {imm, m_regs[d][31:0]} : {m_regs[d][63:32], imm};
            OP_CEQ:  m_flags[d] = (a == b);
            OP_CLT:  m_flags[d] = (a < b);
            OP_FAND: m_flags[d] = m_flags[ra] & m_flags[rb];
            OP_FOR:  m_flags[d] = m_flags[ra] | m_flags[rb];
            OP_BRF:  next_pc = m_flags[ra] ? word_t'(imm) : next_pc;
            OP_JMP:  next_pc = word_t'(imm);
            OP_ST:
            begin
                rec.addr = a;
                rec.data = b;
                exp_stores.push_back(rec);
            end
            OP_STF:
            begin
                rec.addr = a;
                rec.data = word_t'(m_flags);
                exp_stores.push_back(rec);
            end
            OP_HALT: done = 1'b1;
            default: ;
        endcase
        pc = next_pc;
    end
endfunction

`endif

//--- test/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu
    import cpu_pkg::*;
();

    localparam int NUM_TESTS = 8;
    localparam int TAIL_AT   = 30;
    localparam int TIMEOUT   = 2000;

    logic  clock = 1'b0;
    logic  reset = 1'b1;
    logic  imem_req;
    word_t imem_addr;
    logic  imem_ack = 1'b0;
    word_t imem_data = '0;
    logic  dmem_req;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_ack = 1'b0;
    logic  halted;
    logic  retire;

    word_t      prog [64];
    logic [2:0] imem_delay [64];
    logic [2:0] dmem_delay [64];
    int         error_count = 0;
    int         failed_tests = 0;

    `include "cpu_ref_model.svh"

    word_t      fetch_log [$];
    store_rec_t store_log [$];
    logic       imem_busy;
    logic [2:0] imem_wait;
    logic [5:0] imem_count;
    logic       dmem_busy;
    logic [2:0] dmem_wait;
    logic [5:0] dmem_count;
    int         retire_count;

    always #4 clock = ~clock;

    cpu_top DUT (
        .clock      (clock),
        .reset      (reset),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ack   (dmem_ack),
        .halted     (halted),
        .retire     (retire)
    );

    // instruction memory, logs every request address in order
    always @(posedge clock)
    begin
        if (reset)
        begin
            imem_ack   <= 1'b0;
            imem_busy  <= 1'b0;
            imem_count <= '0;
        end
        else if (!imem_busy && imem_req)
        begin
            fetch_log.push_back(imem_addr);
            imem_busy  <= 1'b1;
            imem_wait  <= imem_delay[imem_count];
            imem_count <= imem_count + 1'b1;
        end
        else if (imem_busy && !imem_ack)
        begin
            if (imem_wait == 3'd0)
            begin
                imem_ack  <= 1'b1;
                imem_data <= prog[imem_addr[5:0]];
            end
            else
            begin
                imem_wait <= imem_wait - 1'b1;
            end
        end
        else if (imem_ack && !imem_req)
        begin
            imem_ack  <= 1'b0;
            imem_busy <= 1'b0;
        end
    end

    // data memory only records what is stored
    always @(posedge clock)
    begin
        if (reset)
        begin
            dmem_ack   <= 1'b0;
            dmem_busy  <= 1'b0;
            dmem_count <= '0;
        end
        else if (!dmem_busy && dmem_req)
        begin
            store_log.push_back({dmem_addr, dmem_wdata});
            dmem_busy  <= 1'b1;
            dmem_wait  <= dmem_delay[dmem_count];
            dmem_count <= dmem_count + 1'b1;
        end
        else if (dmem_busy && !dmem_ack)
        begin
            if (dmem_wait == 3'd0)
            begin
                dmem_ack <= 1'b1;
            end
            else
            begin
                dmem_wait <= dmem_wait - 1'b1;
            end
        end
        else if (dmem_ack && !dmem_req)
        begin
            dmem_ack  <= 1'b0;
            dmem_busy <= 1'b0;
        end
    end

    // one pulse per retired instruction
    always @(posedge clock)
    begin
        if (reset)
        begin
            retire_count <= 0;
        end
        else if (retire)
        begin
            retire_count <= retire_count + 1;
        end
    end

    function automatic word_t encode(input logic [5:0] op, input logic [2:0] ra,
                                     input logic [2:0] rb, input logic [2:0] d,
                                     input logic hl, input logic [31:0] imm);
        return {imm, 16'h0000, hl, d, rb, ra, op};
    endfunction

    // LDI twice as likely, last code is undefined and acts as a no-op
    function automatic logic [5:0] pick_op(input logic [3:0] k);
        case (k)
            4'd0:    return OP_ADD;
            4'd1:    return OP_SUB;
            4'd2:    return OP_AND;
            4'd3:    return OP_OR;
            4'd4:    return OP_XOR;
            4'd5:    return OP_LDI;
            4'd6:    return OP_LDI;
            4'd7:    return OP_CEQ;
            4'd8:    return OP_CLT;
            4'd9:    return OP_FAND;
            4'd10:   return OP_FOR;
            4'd11:   return OP_BRF;
            4'd12:   return OP_JMP;
            4'd13:   return OP_ST;
            4'd14:   return OP_STF;
            default: return 6'd42;
        endcase
    endfunction

    // r7 is the store address, loaded by LDI and never written by the ALU
    function automatic void build_program();
        logic [5:0]  op;
        logic [2:0]  ra;
        logic [2:0]  rb;
        logic [2:0]  d;
        logic        hl;
        logic [31:0] imm;
        int          i;
        for (i = 0; i < 64; i++)
        begin
            prog[i]       = {32'(i), 26'h0, 6'd63};
            imem_delay[i] = 3'(rand_bits(3) % 6);
            dmem_delay[i] = 3'(rand_bits(3) % 6);
        end
        prog[0] = encode(OP_LDI, 3'd0, 3'd0, 3'd7, 1'b0, 32'(rand_bits(32)));
        prog[1] = encode(OP_LDI, 3'd0, 3'd0, 3'd7, 1'b1, 32'(rand_bits(32)));
        for (i = 2; i < TAIL_AT; i++)
        begin
            op  = pick_op(4'(rand_bits(4)));
            ra  = 3'(rand_bits(3));
            rb  = 3'(rand_bits(3));
            d   = 3'(rand_bits(3));
            hl  = 1'(rand_bits(1));
            imm = 32'(rand_bits(32));
            case (op)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
                    d = (d == 3'd7) ? 3'd0 : d;
                OP_ST, OP_STF:
                    ra = 3'd7;
                // forward only, at most to the start of the tail
                OP_BRF, OP_JMP:
                    imm = 32'(i + 1) + imm % 32'(TAIL_AT - i);
                default: ;
            endcase
            prog[i] = encode(op, ra, rb, d, hl, imm);
        end
        for (i = 0; i < 8; i++)
        begin
            prog[TAIL_AT + i] = encode(OP_ST, 3'd7, 3'(i), 3'd0, 1'b0, 32'd0);
        end
        prog[TAIL_AT + 8] = encode(OP_STF, 3'd7, 3'd0, 3'd0, 1'b0, 32'd0);
        prog[TAIL_AT + 9] = encode(OP_HALT, 3'd0, 3'd0, 3'd0, 1'b0, 32'd0);
    endfunction

    task automatic run_test(input int t);
        string name;
        int    errs;
        int    cycles;
        int    n;
        logic  held;
        name = $sformatf("random_prog_%0d", t);
        errs = 0;
        @(posedge clock);
        reset <= 1'b1;
        build_program();
        run_model();
        fetch_log.delete();
        store_log.delete();
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert ({imem_req, dmem_req, halted} == 3'b000)
        else
        begin
            $display("[ERROR] %s reset state: expected %b, actual %b", name, 3'b000,
                     {imem_req, dmem_req, halted});
            errs++;
        end

        cycles = 0;
        while (!imem_req && cycles < TIMEOUT)
        begin
            @(negedge clock);
            cycles++;
        end
        assert (imem_req)
        else
        begin
            $display("[ERROR] %s: no instruction fetch was requested after reset", name);
            errs++;
        end
        assert (imem_addr == `CPU_RESET_PC)
        else
        begin
            $display("[ERROR] %s first fetch: expected %h, actual %h", name,
                     word_t'(`CPU_RESET_PC), imem_addr);
            errs++;
        end

        cycles = 0;
        while (!halted && cycles < TIMEOUT)
        begin
            @(negedge clock);
            cycles++;
        end
        assert (halted)
        else
        begin
            $display("[ERROR] %s: the CPU did not halt in time", name);
            errs++;
        end

        if (halted)
        begin
            held = 1'b1;
            for (n = 0; n < 50; n++)
            begin
                @(negedge clock);
                held = held && halted && !imem_req;
            end
            assert (held)
            else
            begin
                $display("[ERROR] %s: halted fell or a fetch started after HALT", name);
                errs++;
            end

            assert (retire_count == exp_pcs.size())
            else
            begin
                $display("[ERROR] %s retire count: expected %0d, actual %0d", name,
                         exp_pcs.size(), retire_count);
                errs++;
            end

            assert (fetch_log.size() == exp_pcs.size())
            else
            begin
                $display("[ERROR] %s fetch count: expected %0d, actual %0d", name,
                         exp_pcs.size(), fetch_log.size());
                errs++;
            end
            for (n = 0; n < exp_pcs.size() && n < fetch_log.size(); n++)
            begin
                assert (fetch_log[n] == exp_pcs[n])
                else
                begin
                    $display("[ERROR] %s fetch %0d: expected %h, actual %h", name, n,
                             exp_pcs[n], fetch_log[n]);
                    errs++;
                end
            end

            assert (store_log.size() == exp_stores.size())
            else
            begin
                $display("[ERROR] %s store count: expected %0d, actual %0d", name,
                         exp_stores.size(), store_log.size());
                errs++;
            end
            for (n = 0; n < exp_stores.size() && n < store_log.size(); n++)
            begin
                assert (store_log[n] == exp_stores[n])
                else
                begin
                    $display("[ERROR] %s store %0d: expected %h/%h, actual %h/%h", name, n,
                             exp_stores[n].addr, exp_stores[n].data,
                             store_log[n].addr, store_log[n].data);
                    errs++;
                end
            end
        end

        if (errs == 0)
        begin
            $display("%s: passed, %0d instructions, %0d stores", name, exp_pcs.size(),
                     exp_stores.size());
        end
        else
        begin
            $display("%s: failed with %0d errors", name, errs);
            failed_tests++;
        end
        error_count += errs;
    endtask

    initial
    begin
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            run_test(t);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS,
                 NUM_TESTS - failed_tests, failed_tests, error_count);
        if (error_count == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+rtl
+incdir+test
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/cpu_top.sv
test/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the result is decided by the pass line in the simulator output
run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q '^NO ERRORS$$'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
